//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_hps_io
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/hps_io_pkg.sv
// hps_io shared definitions
// bus word type, command codes for the user-I/O and file channels,
// keyboard sequence constants and the keyboard scan union
package hps_io_pkg;

	typedef logic [15:0] io_word_t;

	// last four keyboard bytes, byte 0 is the newest
	typedef union packed {
		logic [3:0][7:0] bytes;
		logic [31:0]     code;
	} ps2_scan_u;

	////////////////////////////// user-I/O commands
	localparam io_word_t cmd_cfg        = 16'h0001;
	localparam io_word_t cmd_joy0       = 16'h0002;
	localparam io_word_t cmd_joy1       = 16'h0003;
	localparam io_word_t cmd_kbd        = 16'h0005;
	localparam io_word_t cmd_status     = 16'h001E;
	localparam io_word_t cmd_status_req = 16'h0029;
	localparam io_word_t cmd_info       = 16'h0036;

	////////////////////////////// file commands
	localparam io_word_t fio_file_tx     = 16'h0053;
	localparam io_word_t fio_file_tx_dat = 16'h0054;
	localparam io_word_t fio_file_index  = 16'h0055;
	localparam io_word_t fio_file_info   = 16'h0056;

	// keyboard prefixes and multi-byte sequences
	localparam logic [7:0]  key_release_prefix  = 8'hF0;
	localparam logic [7:0]  key_ext_prefix      = 8'hE0;
	localparam logic [31:0] prnscr_press_code   = 32'hE012E07C;
	localparam logic [31:0] prnscr_release_code = 32'h7CE0F012;
	localparam logic [31:0] pause_press_code    = 32'hF014F077;
	localparam logic [9:0]  prnscr_press_key    = 10'h37C;
	localparam logic [9:0]  prnscr_release_key  = 10'h17C;
	localparam logic [9:0]  pause_press_key     = 10'h377;

	localparam logic [7:0] upload_mode_byte = 8'hAA;
	localparam int status_words = 8;
	localparam int ioctl_addr_w = 27;
	localparam int byte_cnt_w   = 4;

endpackage

//--- compile.f
common/hps_io_pkg.sv
uio/uio_decoder.sv
fio/fio_transfer.sv
src/host_response.sv
src/hps_io_top.sv
sim/hps_io_assertions.sv
sim/tb_hps_io.sv

//--- fio/fio_transfer.sv
// file channel
// handles file index, file extension, download to ioctl_wr and
// upload reads from ioctl_din, framed by fp_enable
`timescale 1ns/10ps

module fio_transfer
	import hps_io_pkg::*;
#(
	parameter WIDE = 0
)
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    io_strobe,
	input  logic                    fp_enable,
	input  io_word_t                io_din,
	input  logic [15:0]             ioctl_din,
	output io_word_t                fp_dout,
	output logic                    ioctl_download,
	output logic                    ioctl_upload,
	output logic [15:0]             ioctl_index,
	output logic [31:0]             ioctl_file_ext,
	output logic                    ioctl_wr,
	output logic [ioctl_addr_w-1:0] ioctl_addr,
	output logic [15:0]             ioctl_dout,
	output logic                    ioctl_rd
);

	localparam io_word_t data_mask = WIDE ? 16'hFFFF : 16'h00FF;
	localparam logic [ioctl_addr_w-1:0] addr_step = WIDE ? 2 : 1;

	io_word_t                cmd_q;
	logic                    has_cmd;
	logic [1:0]              cnt;
	logic [ioctl_addr_w-1:0] addr;
	logic                    wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			has_cmd        <= 1'b0;
			cnt            <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
		end else begin
			ioctl_rd <= 1'b0;
			// write strobe trails the data by one cycle
			ioctl_wr <= wr;
			wr       <= 1'b0;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd_q   <= io_din;
					has_cmd <= 1'b1;
					cnt     <= '0;
				end else begin
					case (cmd_q)
						fio_file_info: begin
							if (cnt == 2'd0) begin
								ioctl_file_ext[31:16] <= io_din;
							end else if (cnt == 2'd1) begin
								ioctl_file_ext[15:0] <= io_din;
							end
							if (!cnt[1]) begin
								cnt <= cnt + 1'b1;
							end
						end
						fio_file_index: ioctl_index <= io_din;
						fio_file_tx: begin
							if (~&cnt) begin
								cnt <= cnt + 1'b1;
							end
							case (cnt)
								2'd0: begin
									// mode word
									if (io_din[7:0] == upload_mode_byte) begin
										ioctl_addr   <= '0;
										ioctl_upload <= 1'b1;
										ioctl_rd     <= 1'b1;
									end else if (io_din[7:0] != 8'h00) begin
										addr           <= '0;
										ioctl_download <= 1'b1;
									end else begin
										// end of transfer, leave the end address visible
										if (ioctl_download) begin
											ioctl_addr <= addr;
										end
										ioctl_download <= 1'b0;
										ioctl_upload   <= 1'b0;
									end
								end
								2'd1: begin
									ioctl_addr[15:0] <= io_din;
									addr[15:0]       <= io_din;
								end
								2'd2: begin
									ioctl_addr[ioctl_addr_w-1:16] <= io_din[ioctl_addr_w-17:0];
									addr[ioctl_addr_w-1:16]       <= io_din[ioctl_addr_w-17:0];
								end
								default: ;
							endcase
						end
						fio_file_tx_dat: begin
							if (ioctl_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din & data_mask;
								wr         <= 1'b1;
								addr       <= addr + addr_step;
							end else if (ioctl_upload) begin
								ioctl_addr <= ioctl_addr + addr_step;
								fp_dout    <= ioctl_din & data_mask;
								ioctl_rd   <= 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- sim/hps_io_assertions.sv
// protocol checks for the host command bridge
// bound into the file channel for the ioctl strobes and into the
// user-I/O decoder for frame cleanup
`timescale 1ns/10ps

module hps_io_assertions
	import hps_io_pkg::*;
#(
	parameter bit file_side = 1'b1
)
(
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  io_enable,
	input logic [byte_cnt_w-1:0] byte_cnt,
	input logic                  ioctl_wr,
	input logic                  ioctl_rd,
	input logic                  ioctl_upload
);

	generate
		if (file_side) begin : g_file
			// no core writes while the core is being read
			wr_not_in_upload: assert property (@(posedge clk_sys) disable iff (reset)
				!(ioctl_wr && ioctl_upload))
				else $error("ioctl_wr high while ioctl_upload is set");

			rd_wr_apart: assert property (@(posedge clk_sys) disable iff (reset)
				!(ioctl_wr && ioctl_rd))
				else $error("ioctl_rd and ioctl_wr high together");
		end else begin : g_uio
			// word count restarts with every frame
			count_clears: assert property (@(posedge clk_sys) disable iff (reset)
				$fell(io_enable) |=> (byte_cnt == '0))
				else $error("byte_cnt not cleared after io_enable fell");
		end
	endgenerate

endmodule

bind fio_transfer hps_io_assertions #(.file_side(1'b1)) i_fio_checks (
	.clk_sys(clk_sys), .reset(reset), .io_enable(1'b1), .byte_cnt('0),
	.ioctl_wr(ioctl_wr), .ioctl_rd(ioctl_rd), .ioctl_upload(ioctl_upload)
);

bind uio_decoder hps_io_assertions #(.file_side(1'b0)) i_uio_checks (
	.clk_sys(clk_sys), .reset(reset), .io_enable(io_enable), .byte_cnt(byte_cnt),
	.ioctl_wr(1'b0), .ioctl_rd(1'b0), .ioctl_upload(1'b0)
);

//--- sim/tb_hps_io.sv
// testbench for the host command bridge
// drives user-I/O and file frames on the host bus, checks the core side
// outputs and the readback words against a model of the decode rules
`timescale 1ns/10ps

module tb_hps_io
	import hps_io_pkg::*;
();

	localparam int n_download = 6;
	localparam int n_upload   = 4;
	localparam int wait_limit = 200;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    io_strobe;
	logic                    io_enable;
	logic                    fp_enable;
	io_word_t                io_din;
	logic [127:0]            status_in;
	logic                    status_set;
	logic                    info_req;
	logic [7:0]              info;
	logic [15:0]             ioctl_din;
	logic                    ioctl_wait;
	io_word_t                io_dout;
	logic                    host_wait;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	logic                    direct_video;
	logic [31:0]             joystick_0;
	logic [31:0]             joystick_1;
	logic [127:0]            status;
	logic [10:0]             ps2_key;
	logic                    ioctl_download;
	logic                    ioctl_upload;
	logic [15:0]             ioctl_index;
	logic [31:0]             ioctl_file_ext;
	logic                    ioctl_wr;
	logic [ioctl_addr_w-1:0] ioctl_addr;
	logic [15:0]             ioctl_dout;
	logic                    ioctl_rd;

	io_word_t                cfg_seen;
	logic [31:0]             lfsr_state = 32'h6648;
	logic                    exp_toggle;
	logic [10:0]             exp_key;
	int                      errors;
	int                      checks;
	int                      tests;
	int                      test_base;
	int                      wr_seen;
	logic [ioctl_addr_w-1:0] exp_addr_q[$];
	io_word_t                exp_data_q[$];

	// config bits in their word positions
	assign cfg_seen = {5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons};

	always #4 clk_sys = ~clk_sys;

	hps_io_top #(.WIDE(0)) i_dut (.*);

	////////////////////////////// stimulus helpers
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// expected key from the last four bytes, newest in the low byte
	function automatic logic [9:0] ref_ps2_key(input logic [31:0] last4);
		logic is_press;
		logic is_ext;
		if (last4 == 32'hE012E07C) begin
			return 10'h37C;
		end
		if (last4 == 32'h7CE0F012) begin
			return 10'h17C;
		end
		if (last4 == 32'hF014F077) begin
			return 10'h377;
		end
		is_press = (last4[15:8] != 8'hF0);
		is_ext   = is_press ? (last4[15:8] == 8'hE0) : (last4[23:16] == 8'hE0);
		return {is_press, is_ext, last4[7:0]};
	endfunction

	////////////////////////////// compare tasks
	task automatic check_word(input string name, input io_word_t got, input io_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_key(input string name, input logic [10:0] got, input logic [10:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [ioctl_addr_w-1:0] got,
		input logic [ioctl_addr_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic test_done(input string name);
		$display("test %-10s finished, %0d errors", name, errors - test_base);
		test_base = errors;
		tests++;
	endtask

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("Something failed");
		$finish;
	endtask

	////////////////////////////// host bus driver
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic frame_open(input logic file_ch);
		if (file_ch) begin
			fp_enable = 1'b1;
		end else begin
			io_enable = 1'b1;
		end
		step();
	endtask

	task automatic frame_close();
		io_enable = 1'b0;
		fp_enable = 1'b0;
		step();
		step();
	endtask

	// one word per strobe, readback sampled the cycle after
	task automatic host_write(input io_word_t word, output io_word_t rd);
		int cycles;
		cycles = 0;
		while (host_wait && cycles < wait_limit) begin
			step();
			cycles++;
		end
		if (host_wait) begin
			abort_run("host_wait stayed high");
		end else begin
			io_din    = word;
			io_strobe = 1'b1;
			step();
			io_strobe = 1'b0;
			rd = io_dout;
		end
	endtask

	// command, then n data words taken low word first
	task automatic send_frame(input logic file_ch, input io_word_t cmd,
		input logic [127:0] data, input int n);
		io_word_t rd;
		frame_open(file_ch);
		host_write(cmd, rd);
		for (int i = 0; i < n; i++) begin
			host_write(data[16*i +: 16], rd);
		end
		frame_close();
	endtask

	task automatic kbd_case(input logic [63:0] seq, input int len);
		io_word_t    rd;
		logic [31:0] last4;
		last4 = '0;
		frame_open(1'b0);
		host_write(cmd_kbd, rd);
		for (int i = 0; i < len; i++) begin
			host_write({8'h00, seq[8*i +: 8]}, rd);
			last4 = {last4[23:0], seq[8*i +: 8]};
		end
		frame_close();
		exp_toggle = ~exp_toggle;
		exp_key    = {exp_toggle, ref_ps2_key(last4)};
		check_key("ps2_key", ps2_key, exp_key);
	endtask

	// pairs each ioctl_wr pulse with the oldest pending write
	task automatic watch_writes();
		forever begin
			@(negedge clk_sys);
			if (ioctl_wr) begin
				if (exp_addr_q.size() == 0) begin
					errors++;
					$display("ioctl_wr pulsed with no write pending");
				end else begin
					check_addr("ioctl_addr", ioctl_addr, exp_addr_q.pop_front());
					check_word("ioctl_dout", ioctl_dout, exp_data_q.pop_front());
				end
				wr_seen++;
			end
		end
	endtask

	task automatic wait_writes(input int n);
		int cycles;
		cycles = 0;
		while (wr_seen < n && cycles < wait_limit) begin
			step();
			cycles++;
		end
		if (wr_seen < n) begin
			abort_run("too few ioctl_wr pulses");
		end
	endtask

	////////////////////////////// test sequence
	initial begin : main
		io_word_t     rd;
		io_word_t     w;
		io_word_t     hi;
		logic [7:0]   kb;
		logic [127:0] exp_status;
		logic [26:0]  start;

		reset      = 1'b1;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		info_req   = 1'b0;
		info       = '0;
		ioctl_din  = '0;
		ioctl_wait = 1'b0;
		exp_toggle = 1'b0;
		exp_key    = '0;
		errors     = 0;
		checks     = 0;
		tests      = 0;
		test_base  = 0;
		wr_seen    = 0;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		fork
			watch_writes();
		join_none

		check_word("io_dout", io_dout, 16'h0000);
		check_key("ps2_key", ps2_key, 11'h000);
		check_word("cfg", cfg_seen, 16'h0000);
		check_word("ioctl flags", {12'h000, ioctl_wr, ioctl_rd, ioctl_download, ioctl_upload},
			16'h0000);
		test_done("reset");

		w = 16'(rand_bits(16));
		send_frame(1'b0, cmd_cfg, {112'h0, w}, 1);
		check_word("cfg", cfg_seen, w & 16'h0413);
		w  = 16'(rand_bits(16));
		hi = 16'(rand_bits(16));
		send_frame(1'b0, cmd_joy0, {96'h0, hi, w}, 2);
		check_word("joystick_0[15:0]", joystick_0[15:0], w);
		check_word("joystick_0[31:16]", joystick_0[31:16], hi);
		w  = 16'(rand_bits(16));
		hi = 16'(rand_bits(16));
		send_frame(1'b0, cmd_joy1, {96'h0, hi, w}, 2);
		check_word("joystick_1[15:0]", joystick_1[15:0], w);
		check_word("joystick_1[31:16]", joystick_1[31:16], hi);
		test_done("cfg_joy");

		exp_status = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
		send_frame(1'b0, cmd_status, exp_status, 8);
		check_status("status", status, exp_status);
		test_done("status");

		kb = 8'(rand_bits(8));
		kbd_case({56'h0, kb}, 1);
		kbd_case({48'h0, kb, 8'hF0}, 2);
		kbd_case({48'h0, kb, 8'hE0}, 2);
		kbd_case(64'h7CE012E0, 4);
		kbd_case(64'h12F0E07CF0E0, 6);
		kbd_case(64'h77F014F0E17714E1, 8);
		// skipped frame leaves key and toggle alone
		send_frame(1'b0, cmd_kbd, {96'h0, 16'h001C, 16'hFF12}, 2);
		check_key("ps2_key", ps2_key, exp_key);
		test_done("keyboard");

		status_in  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
		status_set = 1'b1;
		step();
		status_set = 1'b0;
		step();
		frame_open(1'b0);
		host_write(cmd_status_req, rd);
		check_word("io_dout", rd, 16'h00A1);
		for (int i = 0; i < 8; i++) begin
			host_write(16'h0000, rd);
			check_word("io_dout", rd, status_in[16*i +: 16]);
		end
		frame_close();
		info     = 8'(rand_bits(8));
		info_req = 1'b1;
		step();
		info_req = 1'b0;
		frame_open(1'b0);
		host_write(cmd_info, rd);
		check_word("io_dout", rd, {8'h00, info});
		frame_close();
		frame_open(1'b0);
		host_write(cmd_info, rd);
		check_word("io_dout", rd, 16'h0000);
		frame_close();
		test_done("readback");

		start = 27'(rand_bits(27));
		send_frame(1'b1, fio_file_tx, {85'h0, start[26:16], start[15:0], 16'h0001}, 3);
		check_word("ioctl_download", {15'b0, ioctl_download}, 16'h0001);
		frame_open(1'b1);
		host_write(fio_file_tx_dat, rd);
		for (int i = 0; i < n_download; i++) begin
			w = 16'(rand_bits(16));
			exp_addr_q.push_back(start + 27'(i));
			exp_data_q.push_back(w & 16'h00FF);
			host_write(w, rd);
			// idle cycle so each write strobe meets its own address
			step();
		end
		wait_writes(n_download);
		frame_close();
		send_frame(1'b1, fio_file_tx, 128'h0, 1);
		check_word("ioctl_download", {15'b0, ioctl_download}, 16'h0000);
		check_addr("ioctl_addr", ioctl_addr, start + 27'(n_download));
		test_done("download");

		frame_open(1'b1);
		host_write(fio_file_tx, rd);
		host_write(16'h00AA, rd);
		check_word("ioctl_rd", {15'b0, ioctl_rd}, 16'h0001);
		frame_close();
		check_word("ioctl_upload", {15'b0, ioctl_upload}, 16'h0001);
		frame_open(1'b1);
		host_write(fio_file_tx_dat, rd);
		for (int i = 0; i < n_upload; i++) begin
			w         = 16'(rand_bits(16));
			ioctl_din = w;
			host_write(16'h0000, rd);
			check_word("io_dout", rd, w & 16'h00FF);
			check_word("ioctl_rd", {15'b0, ioctl_rd}, 16'h0001);
			check_addr("ioctl_addr", ioctl_addr, 27'(i + 1));
		end
		frame_close();
		send_frame(1'b1, fio_file_tx, 128'h0, 1);
		check_word("ioctl_upload", {15'b0, ioctl_upload}, 16'h0000);
		test_done("upload");

		w = 16'(rand_bits(16));
		send_frame(1'b1, fio_file_index, {112'h0, w}, 1);
		check_word("ioctl_index", ioctl_index, w);
		// extension goes high half first
		w  = 16'(rand_bits(16));
		hi = 16'(rand_bits(16));
		send_frame(1'b1, fio_file_info, {96'h0, w, hi}, 2);
		check_word("ioctl_file_ext[31:16]", ioctl_file_ext[31:16], hi);
		check_word("ioctl_file_ext[15:0]", ioctl_file_ext[15:0], w);
		ioctl_wait = 1'b1;
		step();
		check_word("host_wait", {15'b0, host_wait}, 16'h0001);
		ioctl_wait = 1'b0;
		step();
		check_word("host_wait", {15'b0, host_wait}, 16'h0000);
		test_done("file_info");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- src/host_response.sv
// host readback
// builds the user-I/O readback word (status request, info) and
// selects the file channel word while fp_enable is high
`timescale 1ns/10ps

module host_response
	import hps_io_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_strobe,
	input  logic                  io_enable,
	input  logic                  fp_enable,
	input  io_word_t              cmd,
	input  logic [byte_cnt_w-1:0] byte_cnt,
	input  logic [127:0]          status_in,
	input  logic                  status_set,
	input  logic                  info_req,
	input  logic [7:0]            info,
	input  io_word_t              fp_dout,
	output io_word_t              io_dout
);

	io_word_t                      uio_dout;
	logic [status_words-1:0][15:0] status_req;
	logic [3:0]                    stflg;
	logic                          old_status_set;
	logic                          old_info_req;
	logic [7:0]                    info_n;
	logic [2:0]                    slot;

	assign slot    = byte_cnt[2:0] - 3'd1;
	assign io_dout = fp_enable ? fp_dout : uio_dout;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			uio_dout       <= '0;
			stflg          <= '0;
			old_status_set <= 1'b0;
			old_info_req   <= 1'b0;
			info_n         <= '0;
		end else begin
			// snapshot of status_in on each status_set edge
			old_status_set <= status_set;
			if (!old_status_set && status_set) begin
				stflg      <= stflg + 1'b1;
				status_req <= status_in;
			end
			old_info_req <= info_req;
			if (!old_info_req && info_req) begin
				info_n <= info;
			end

			if (!io_enable) begin
				uio_dout <= '0;
			end else if (io_strobe) begin
				uio_dout <= '0;
				if (byte_cnt == '0) begin
					case (cmd)
						cmd_status_req: uio_dout <= {8'h00, 4'hA, stflg};
						cmd_info: begin
							uio_dout <= {8'h00, info_n};
							info_n   <= '0;
						end
						default: ;
					endcase
				end else if (cmd == cmd_status_req && byte_cnt <= status_words) begin
					uio_dout <= status_req[slot];
				end
			end
		end
	end

endmodule

//--- src/hps_io_top.sv
// host command bridge, top level
// user-I/O decoder and file channel side by side, readback merged
// into one host word
`timescale 1ns/10ps

module hps_io_top
	import hps_io_pkg::*;
#(
	parameter WIDE = 0
)
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    io_strobe,
	input  logic                    io_enable,
	input  logic                    fp_enable,
	input  io_word_t                io_din,
	input  logic [127:0]            status_in,
	input  logic                    status_set,
	input  logic                    info_req,
	input  logic [7:0]              info,
	input  logic [15:0]             ioctl_din,
	input  logic                    ioctl_wait,
	output io_word_t                io_dout,
	output logic                    host_wait,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output logic [31:0]             joystick_0,
	output logic [31:0]             joystick_1,
	output logic [127:0]            status,
	output logic [10:0]             ps2_key,
	output logic                    ioctl_download,
	output logic                    ioctl_upload,
	output logic [15:0]             ioctl_index,
	output logic [31:0]             ioctl_file_ext,
	output logic                    ioctl_wr,
	output logic [ioctl_addr_w-1:0] ioctl_addr,
	output logic [15:0]             ioctl_dout,
	output logic                    ioctl_rd
);

	io_word_t              cmd;
	logic [byte_cnt_w-1:0] byte_cnt;
	io_word_t              fp_dout;

	// the host stalls its strobes on this
	assign host_wait = ioctl_wait;

	uio_decoder u_uio (
		.clk_sys(clk_sys), .reset(reset), .io_strobe(io_strobe),
		.io_enable(io_enable), .io_din(io_din), .cmd(cmd), .byte_cnt(byte_cnt),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status), .ps2_key(ps2_key)
	);

	fio_transfer #(.WIDE(WIDE)) u_fio (
		.clk_sys(clk_sys), .reset(reset), .io_strobe(io_strobe),
		.fp_enable(fp_enable), .io_din(io_din), .ioctl_din(ioctl_din),
		.fp_dout(fp_dout), .ioctl_download(ioctl_download),
		.ioctl_upload(ioctl_upload), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_rd(ioctl_rd)
	);

	host_response u_resp (
		.clk_sys(clk_sys), .reset(reset), .io_strobe(io_strobe),
		.io_enable(io_enable), .fp_enable(fp_enable), .cmd(cmd),
		.byte_cnt(byte_cnt), .status_in(status_in), .status_set(status_set),
		.info_req(info_req), .info(info), .fp_dout(fp_dout), .io_dout(io_dout)
	);

endmodule

//--- uio/uio_decoder.sv
// user-I/O frame decoder
// tracks io_enable frames, latches the command word and counts data words,
// then decodes config, joystick, 128-bit status and keyboard frames
`timescale 1ns/10ps

module uio_decoder
	import hps_io_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_strobe,
	input  logic                  io_enable,
	input  io_word_t              io_din,
	output io_word_t              cmd,
	output logic [byte_cnt_w-1:0] byte_cnt,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output logic                  direct_video,
	output logic [31:0]           joystick_0,
	output logic [31:0]           joystick_1,
	output logic [127:0]          status,
	output logic [10:0]           ps2_key
);

	io_word_t   cmd_q;
	io_word_t   cfg;
	ps2_scan_u  scan;
	logic       skip;
	logic       pressed;
	logic       extended;
	logic [9:0] key_low;
	logic [2:0] slot;
	logic       in_status;

	// command in effect for this strobe, the word itself on word 0
	assign cmd = (byte_cnt == '0) ? io_din : cmd_q;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// data word n goes to status slice n-1
	assign slot      = byte_cnt[2:0] - 3'd1;
	assign in_status = (byte_cnt != '0) && (byte_cnt <= status_words);

	////////////////////////////// keyboard decode
	assign pressed  = (scan.bytes[1] != key_release_prefix);
	assign extended = pressed ? (scan.bytes[1] == key_ext_prefix) :
		(scan.bytes[2] == key_ext_prefix);

	always_comb begin
		case (scan.code)
			prnscr_press_code:   key_low = prnscr_press_key;
			prnscr_release_code: key_low = prnscr_release_key;
			pause_press_code:    key_low = pause_press_key;
			default:             key_low = {pressed, extended, scan.bytes[0]};
		endcase
	end

	////////////////////////////// frame handling
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_q      <= '0;
			byte_cnt   <= '0;
			skip       <= 1'b0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			ps2_key    <= '0;
		end else if (!io_enable) begin
			// end of frame, publish the key once
			if (cmd_q == cmd_kbd && !skip) begin
				ps2_key <= {~ps2_key[10], key_low};
			end
			cmd_q    <= '0;
			byte_cnt <= '0;
			skip     <= 1'b0;
		end else if (io_strobe) begin
			if (~&byte_cnt) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			if (byte_cnt == '0) begin
				cmd_q <= io_din;
				if (io_din == cmd_kbd) begin
					scan.code <= '0;
				end
			end else begin
				case (cmd_q)
					cmd_cfg: cfg <= io_din;
					cmd_joy0: begin
						if (byte_cnt == 4'd1) begin
							joystick_0[15:0] <= io_din;
						end else begin
							joystick_0[31:16] <= io_din;
						end
					end
					cmd_joy1: begin
						if (byte_cnt == 4'd1) begin
							joystick_1[15:0] <= io_din;
						end else begin
							joystick_1[31:16] <= io_din;
						end
					end
					cmd_status: begin
						if (in_status) begin
							status[16*slot +: 16] <= io_din;
						end
					end
					cmd_kbd: begin
						// high byte all ones, drop the rest of the frame
						if (&io_din[15:8]) begin
							skip <= 1'b1;
						end else if (!skip) begin
							scan.code <= {scan.code[23:0], io_din[7:0]};
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule
